// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -j 0
TOP       ?= tb_top
FLIST     ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

SRCS := $(wildcard logic/*.sv bench/*.sv include/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Testbench failed" $(LOG); then exit 1; fi
	@grep -q "Testbench passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bench/axi_mem_model.sv
`timescale 1ns/100ps
`include "bridge_params.svh"

module axi_mem_model
#(
	parameter logic [31:0] fill_k = 32'h9e37_79b1
)
(
	input  logic clk,
	input  axi_pkg::axi_ar_t ar,
	input  logic ar_valid,
	output logic ar_ready,
	output axi_pkg::axi_r_t r,
	output logic r_valid,
	input  axi_pkg::axi_aw_t aw,
	input  logic aw_valid,
	output logic aw_ready,
	input  axi_pkg::axi_w_t w,
	input  logic w_valid,
	output logic w_ready,
	output axi_pkg::axi_b_t b,
	output logic b_valid
);
	localparam int words = 1024; // 4 KB

	logic [`BR_DATA_W-1:0] mem [words];
	axi_pkg::axi_ar_t rd_q [$];

	function automatic int word_idx(input logic [`BR_ADDR_W-1:0] addr);
		word_idx = int'(addr[11:2]);
	endfunction

	initial
	begin
		for (int i = 0; i < words; i++)
			mem[i] = 32'(i) * fill_k;
	end

	// random ready delay on read addresses
	initial
	begin
		axi_pkg::axi_ar_t a;
		ar_ready = 1'b0;
		forever
		begin
			@(negedge clk);
			ar_ready = 1'b0;
			if (ar_valid)
			begin
				repeat ($urandom_range(0, 3)) @(negedge clk);
				a = ar;
				ar_ready = 1'b1;
				@(posedge clk);
				rd_q.push_back(a); // queued only after the handshake
			end
		end
	end

	// read bursts served in order
	initial
	begin
		axi_pkg::axi_ar_t a;
		logic [`BR_ADDR_W-1:0] addr;
		r_valid = 1'b0;
		r = '0;
		forever
		begin
			@(negedge clk);
			r_valid = 1'b0;
			if (rd_q.size() > 0)
			begin
				a = rd_q.pop_front();
				repeat ($urandom_range(0, 3)) @(negedge clk);
				for (int k = 0; k <= int'(a.len); k++)
				begin
					addr = (a.burst == `BR_BURST_INCR) ? a.addr + 32'(k * 4) : a.addr;
					r.id = a.id;
					r.data = mem[word_idx(addr)];
					r.resp = 2'b00;
					r.last = (k == int'(a.len));
					r_valid = 1'b1;
					@(negedge clk);
				end
				r_valid = 1'b0;
			end
		end
	end

	// write address and data beats followed by the response
	initial
	begin
		axi_pkg::axi_aw_t a;
		axi_pkg::axi_w_t wb;
		logic [`BR_ADDR_W-1:0] addr;
		int k;
		aw_ready = 1'b0;
		w_ready = 1'b0;
		b_valid = 1'b0;
		b = '0;
		forever
		begin
			@(negedge clk);
			aw_ready = 1'b0;
			if (aw_valid)
			begin
				repeat ($urandom_range(0, 3)) @(negedge clk);
				a = aw;
				aw_ready = 1'b1;
				@(posedge clk);
				k = 0;
				do
				begin
					@(negedge clk);
					aw_ready = 1'b0;
					w_ready = 1'b0;
					repeat ($urandom_range(0, 3)) @(negedge clk);
					while (!w_valid)
						@(negedge clk);
					wb = w;
					w_ready = 1'b1;
					@(posedge clk);
					addr = (a.burst == `BR_BURST_INCR) ? a.addr + 32'(k * 4) : a.addr;
					for (int by = 0; by < `BR_DATA_W / 8; by++)
						if (wb.strb[by])
							mem[word_idx(addr)][8*by +: 8] = wb.data[8*by +: 8];
					k++;
				end
				while (!wb.last);
				@(negedge clk);
				w_ready = 1'b0;
				repeat ($urandom_range(0, 3)) @(negedge clk);
				b.id = a.id;
				b.resp = 2'b00;
				b_valid = 1'b1;
				@(negedge clk);
				b_valid = 1'b0;
			end
		end
	end

endmodule

// File: bench/tb_checker.sv
`timescale 1ns/100ps
`include "bridge_params.svh"

module tb_checker
#(
	parameter logic [31:0] fill_k = 32'h9e37_79b1
)
(
	input  logic clk,
	input  logic rst,
	input  cache_if_pkg::cache_rd_req_t inst_req,
	input  logic inst_valid,
	input  logic inst_rdy,
	input  cache_if_pkg::cache_ret_t inst_ret,
	input  logic inst_ret_valid,
	input  cache_if_pkg::cache_rd_req_t data_req,
	input  logic data_valid,
	input  logic data_rdy,
	input  cache_if_pkg::cache_ret_t data_ret,
	input  logic data_ret_valid,
	input  cache_if_pkg::cache_wr_req_t data_wr_req,
	input  logic data_wr_valid,
	input  logic data_wr_rdy,
	input  logic b_valid,
	input  int test_num,
	input  logic test_done,
	output int n_pass,
	output int n_fail,
	output int n_err
);
	localparam int line_sh = $clog2(`BR_LINE_WORDS * `BR_DATA_W / 8); // bytes per line

	logic [`BR_DATA_W-1:0] shadow [int]; // words changed by completed writes
	cache_if_pkg::cache_wr_req_t wr_q;
	logic pend_w;
	logic pend_i;
	logic pend_d;
	logic [`BR_ADDR_W-1:0] base_i;
	logic [`BR_ADDR_W-1:0] base_d;
	logic unc_d;
	int beat_i;
	int beat_d;
	int err_mark;

	// expected memory word is the fill rule overlaid with finished writes
	function automatic logic [`BR_DATA_W-1:0] exp_word(input logic [`BR_ADDR_W-1:0] addr);
		int idx;
		idx = int'(addr[11:2]);
		if (shadow.exists(idx))
			return shadow[idx];
		return 32'(idx) * fill_k;
	endfunction

	function automatic logic same_line(input logic [`BR_ADDR_W-1:0] x,
		input logic [`BR_ADDR_W-1:0] y);
		return (x >> line_sh) == (y >> line_sh);
	endfunction

	task automatic check_beat(input string src, input logic [`BR_ADDR_W-1:0] base,
		input logic unc, input int beat, input cache_if_pkg::cache_ret_t ret);
		logic [`BR_ADDR_W-1:0] a;
		logic [`BR_DATA_W-1:0] e;
		logic el;
		a = unc ? base : base + 32'(beat * 4);
		e = exp_word(a);
		el = unc || (beat == `BR_LINE_WORDS - 1);
		if (ret.data !== e)
		begin
			$display("mismatch at %0t: %s beat %0d addr %h read %h expected %h",
				$time, src, beat, a, ret.data, e);
			n_err++;
		end
		if (ret.last !== el)
		begin
			$display("mismatch at %0t: %s beat %0d last flag %b expected %b",
				$time, src, beat, ret.last, el);
			n_err++;
		end
	endtask

	always @(posedge clk)
	begin
		if (!rst)
		begin
			pend_w = 1'b0;
			pend_i = 1'b0;
			pend_d = 1'b0;
			n_pass = 0;
			n_fail = 0;
			n_err = 0;
			err_mark = 0;
		end
		else
		begin
			// a completed write lands in the shadow copy
			if (b_valid && pend_w)
			begin
				if (wr_q.uncached)
				begin
					logic [`BR_DATA_W-1:0] v;
					v = exp_word(wr_q.addr);
					for (int by = 0; by < `BR_DATA_W / 8; by++)
						if (wr_q.wstrb[by])
							v[8*by +: 8] = wr_q.line[8*by +: 8];
					shadow[int'(wr_q.addr[11:2])] = v;
				end
				else
					for (int i = 0; i < `BR_LINE_WORDS; i++)
						shadow[int'(wr_q.addr[11:2]) + i] = wr_q.line[32*i +: 32];
				pend_w = 1'b0;
			end
			if (data_wr_valid && data_wr_rdy)
			begin
				wr_q = data_wr_req;
				pend_w = 1'b1;
			end

			// no read may start on a line whose write has no response yet
			if (pend_w && inst_valid && inst_rdy && same_line(inst_req.addr, wr_q.addr))
			begin
				$display("instruction read of %h accepted at %0t while its line was being written",
					inst_req.addr, $time);
				n_err++;
			end
			if (pend_w && data_valid && data_rdy && same_line(data_req.addr, wr_q.addr))
			begin
				$display("data read of %h accepted at %0t while its line was being written",
					data_req.addr, $time);
				n_err++;
			end

			if (data_valid && data_rdy && inst_valid)
			begin
				$display("data read accepted at %0t while an instruction read was waiting", $time);
				n_err++;
			end

			if (inst_ret_valid)
			begin
				if (!pend_i)
				begin
					$display("instruction return at %0t with no read outstanding", $time);
					n_err++;
				end
				else
				begin
					check_beat("inst", base_i, 1'b0, beat_i, inst_ret);
					beat_i++;
					if (beat_i == `BR_LINE_WORDS)
						pend_i = 1'b0;
				end
			end
			if (data_ret_valid)
			begin
				if (!pend_d)
				begin
					$display("data return at %0t with no read outstanding", $time);
					n_err++;
				end
				else
				begin
					check_beat("data", base_d, unc_d, beat_d, data_ret);
					beat_d++;
					if (unc_d || beat_d == `BR_LINE_WORDS)
						pend_d = 1'b0;
				end
			end

			// new requests are taken after this edge's beats
			if (inst_valid && inst_rdy)
			begin
				base_i = inst_req.addr;
				beat_i = 0;
				pend_i = 1'b1;
			end
			if (data_valid && data_rdy)
			begin
				base_d = data_req.addr;
				unc_d = data_req.uncached;
				beat_d = 0;
				pend_d = 1'b1;
			end

			if (test_done)
			begin
				if (pend_i || pend_d || pend_w)
				begin
					$display("test %0d ended with a read or write still outstanding", test_num);
					n_err++;
				end
				if (n_err == err_mark)
				begin
					$display("test %0d passed", test_num);
					n_pass++;
				end
				else
				begin
					$display("test %0d failed with %0d errors", test_num, n_err - err_mark);
					n_fail++;
				end
				err_mark = n_err;
			end
		end
	end

endmodule

// File: bench/tb_clk_gen.sv
`timescale 1ns/100ps

module tb_clk_gen
(
	output logic clk,
	output logic rst
);
	localparam real half_period = 10.0; // 20 ns clock
	localparam int reset_cycles = 10;

	initial
	begin
		clk = 1'b0;
		forever
			#(half_period) clk = ~clk;
	end

	initial
	begin
		rst = 1'b0;
		repeat (reset_cycles) @(posedge clk);
		@(negedge clk);
		rst = 1'b1; // released away from the active edge
	end

endmodule

// File: bench/tb_top.sv
`timescale 1ns/100ps
`include "bridge_params.svh"

module tb_top;
	localparam logic [31:0] fill_k = 32'h9e37_79b1;
	localparam int n_tests = 6;
	localparam int cycle_limit = n_tests * 200 + 300; // 1500 cycles

	logic clk;
	logic rst;
	cache_if_pkg::cache_rd_req_t inst_req;
	logic inst_valid;
	logic inst_rdy;
	cache_if_pkg::cache_ret_t inst_ret;
	logic inst_ret_valid;
	cache_if_pkg::cache_rd_req_t data_req;
	logic data_valid;
	logic data_rdy;
	cache_if_pkg::cache_ret_t data_ret;
	logic data_ret_valid;
	cache_if_pkg::cache_wr_req_t data_wr_req;
	logic data_wr_valid;
	logic data_wr_rdy;
	axi_pkg::axi_ar_t ar;
	logic ar_valid;
	logic ar_ready;
	axi_pkg::axi_r_t r;
	logic r_valid;
	axi_pkg::axi_aw_t aw;
	logic aw_valid;
	logic aw_ready;
	axi_pkg::axi_w_t w;
	logic w_valid;
	logic w_ready;
	axi_pkg::axi_b_t b;
	logic b_valid;
	int test_num;
	logic test_done;
	int n_pass;
	int n_fail;
	int n_err;
	int cycles;

	tb_clk_gen clk_i (.clk(clk), .rst(rst));

	cache_axi_bridge dut_i (.*);

	axi_mem_model #(.fill_k(fill_k)) mem_i
	(
		.clk(clk), .ar(ar), .ar_valid(ar_valid), .ar_ready(ar_ready),
		.r(r), .r_valid(r_valid), .aw(aw), .aw_valid(aw_valid), .aw_ready(aw_ready),
		.w(w), .w_valid(w_valid), .w_ready(w_ready), .b(b), .b_valid(b_valid)
	);

	tb_checker #(.fill_k(fill_k)) chk_i (.*);

	// hard stop if something never completes
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= cycle_limit)
		begin
			$display("run timed out after %0d cycles", cycles);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic request_read(input bit is_data, input logic [31:0] addr, input bit unc);
		cache_if_pkg::cache_rd_req_t q;
		q.addr = addr;
		q.size = 3'd2;
		q.uncached = unc;
		@(negedge clk);
		if (is_data)
		begin
			data_req = q;
			data_valid = 1'b1;
		end
		else
		begin
			inst_req = q;
			inst_valid = 1'b1;
		end
		#1;
		while (!(is_data ? data_rdy : inst_rdy))
		begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		if (is_data)
			data_valid = 1'b0;
		else
			inst_valid = 1'b0;
	endtask

	task automatic wait_last(input bit is_data);
		do
			@(posedge clk);
		while (!(is_data ? (data_ret_valid && data_ret.last) : (inst_ret_valid && inst_ret.last)));
	endtask

	task automatic request_write(input logic [31:0] addr, input bit unc, input logic [3:0] strb);
		cache_if_pkg::cache_wr_req_t q;
		q.addr = addr;
		q.size = 3'd2;
		q.wstrb = strb;
		q.uncached = unc;
		for (int i = 0; i < `BR_LINE_WORDS; i++)
			q.line[32*i +: 32] = $urandom;
		@(negedge clk);
		data_wr_req = q;
		data_wr_valid = 1'b1;
		#1;
		while (!data_wr_rdy)
		begin
			@(negedge clk);
			#1;
		end
		@(negedge clk);
		data_wr_valid = 1'b0;
	endtask

	task automatic wait_write_done();
		do
			@(negedge clk);
		while (!data_wr_rdy);
	endtask

	task automatic end_test(input int n);
		@(negedge clk);
		test_num = n;
		test_done = 1'b1;
		@(negedge clk);
		test_done = 1'b0;
	endtask

	initial
	begin
		bit got_i;
		bit got_d;
		bit drop_i;
		bit drop_d;
		void'($urandom(32'ha8cb_bcf3));
		cycles = 0;
		inst_req = '0;
		inst_valid = 1'b0;
		data_req = '0;
		data_valid = 1'b0;
		data_wr_req = '0;
		data_wr_valid = 1'b0;
		test_num = 0;
		test_done = 1'b0;
		@(posedge rst);

		request_read(1'b0, 32'h100, 1'b0); // instruction line
		wait_last(1'b0);
		end_test(1);

		request_read(1'b1, 32'h244, 1'b1); // uncached load
		wait_last(1'b1);
		end_test(2);

		// both sources in the same cycle
		@(negedge clk);
		inst_req = '{addr: 32'h400, size: 3'd2, uncached: 1'b0};
		data_req = '{addr: 32'h800, size: 3'd2, uncached: 1'b0};
		inst_valid = 1'b1;
		data_valid = 1'b1;
		while (inst_valid || data_valid)
		begin
			#1;
			drop_i = inst_valid && inst_rdy;
			drop_d = data_valid && data_rdy;
			@(negedge clk);
			if (drop_i)
				inst_valid = 1'b0;
			if (drop_d)
				data_valid = 1'b0;
		end
		got_i = 1'b0;
		got_d = 1'b0;
		while (!(got_i && got_d))
		begin
			@(posedge clk);
			got_i = got_i || (inst_ret_valid && inst_ret.last);
			got_d = got_d || (data_ret_valid && data_ret.last);
		end
		end_test(3);

		request_write(32'h600, 1'b0, 4'hf); // line write then read back
		wait_write_done();
		request_read(1'b1, 32'h600, 1'b0);
		wait_last(1'b1);
		end_test(4);

		request_write(32'h348, 1'b1, 4'b0101); // partial uncached store
		wait_write_done();
		request_read(1'b1, 32'h348, 1'b1);
		wait_last(1'b1);
		end_test(5);

		request_write(32'ha00, 1'b0, 4'hf); // read while the write is open
		request_read(1'b1, 32'ha00, 1'b0);
		wait_last(1'b1);
		wait_write_done();
		end_test(6);

		@(negedge clk);
		$display("tests passed %0d, failed %0d, errors %0d", n_pass, n_fail, n_err);
		if (n_fail == 0 && n_err == 0 && n_pass == n_tests)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// File: include/bridge_params.svh
`ifndef BRIDGE_PARAMS_SVH
`define BRIDGE_PARAMS_SVH

// bus widths
`define BR_ADDR_W 32
`define BR_DATA_W 32
`define BR_ID_W 4

// one cache line is 16 words
`define BR_LINE_WORDS 16
`define BR_LINE_W 512

// AXI3 burst length codes (beats minus one)
`define BR_LEN_LINE 4'd15
`define BR_LEN_ONE 4'd0

// burst type codes
`define BR_BURST_INCR 2'b01
`define BR_BURST_FIXED 2'b00

// bit 0 of the read id tells the sources apart
`define BR_ID_INST 4'd0
`define BR_ID_DATA 4'd1

`endif

// File: logic/axi_pkg.sv
`include "bridge_params.svh"

package axi_pkg;

	// read address channel
	typedef struct packed
	{
		logic [`BR_ID_W-1:0] id;
		logic [`BR_ADDR_W-1:0] addr;
		logic [3:0] len; // AXI3 length field
		logic [2:0] size;
		logic [1:0] burst;
	} axi_ar_t;

	typedef struct packed
	{
		logic [`BR_ID_W-1:0] id;
		logic [`BR_DATA_W-1:0] data;
		logic [1:0] resp;
		logic last;
	} axi_r_t;

	// write address channel has the same layout as ar
	typedef struct packed
	{
		logic [`BR_ID_W-1:0] id;
		logic [`BR_ADDR_W-1:0] addr;
		logic [3:0] len;
		logic [2:0] size;
		logic [1:0] burst;
	} axi_aw_t;

	typedef struct packed
	{
		logic [`BR_DATA_W-1:0] data;
		logic [`BR_DATA_W/8-1:0] strb;
		logic last;
	} axi_w_t;

	typedef struct packed
	{
		logic [`BR_ID_W-1:0] id;
		logic [1:0] resp;
	} axi_b_t;

endpackage

// File: logic/cache_axi_bridge.sv
`timescale 1ns/100ps
`include "bridge_params.svh"

module cache_axi_bridge
(
	input  logic clk,
	input  logic rst,
	input  cache_if_pkg::cache_rd_req_t inst_req,
	input  logic inst_valid,
	output logic inst_rdy,
	output cache_if_pkg::cache_ret_t inst_ret,
	output logic inst_ret_valid,
	input  cache_if_pkg::cache_rd_req_t data_req,
	input  logic data_valid,
	output logic data_rdy,
	output cache_if_pkg::cache_ret_t data_ret,
	output logic data_ret_valid,
	input  cache_if_pkg::cache_wr_req_t data_wr_req,
	input  logic data_wr_valid,
	output logic data_wr_rdy,
	output axi_pkg::axi_ar_t ar,
	output logic ar_valid,
	input  logic ar_ready,
	input  axi_pkg::axi_r_t r,
	input  logic r_valid,
	output axi_pkg::axi_aw_t aw,
	output logic aw_valid,
	input  logic aw_ready,
	output axi_pkg::axi_w_t w,
	output logic w_valid,
	input  logic w_ready,
	input  axi_pkg::axi_b_t b,
	input  logic b_valid
);
	logic wr_busy; // write in progress flag for the read hazard check
	logic [`BR_ADDR_W-1:0] wr_addr;

	rd_arbiter rd_i
	(
		.clk            (clk),
		.rst            (rst),
		.inst_req       (inst_req),
		.inst_valid     (inst_valid),
		.inst_rdy       (inst_rdy),
		.inst_ret       (inst_ret),
		.inst_ret_valid (inst_ret_valid),
		.data_req       (data_req),
		.data_valid     (data_valid),
		.data_rdy       (data_rdy),
		.data_ret       (data_ret),
		.data_ret_valid (data_ret_valid),
		.wr_busy        (wr_busy),
		.wr_addr        (wr_addr),
		.ar             (ar),
		.ar_valid       (ar_valid),
		.ar_ready       (ar_ready),
		.r              (r),
		.r_valid        (r_valid)
	);

	wr_burst wr_i
	(
		.clk      (clk),
		.rst      (rst),
		.req      (data_wr_req),
		.valid    (data_wr_valid),
		.rdy      (data_wr_rdy),
		.aw       (aw),
		.aw_valid (aw_valid),
		.aw_ready (aw_ready),
		.w        (w),
		.w_valid  (w_valid),
		.w_ready  (w_ready),
		.b        (b),
		.b_valid  (b_valid),
		.wr_busy  (wr_busy),
		.wr_addr  (wr_addr)
	);

endmodule

// File: logic/cache_if_pkg.sv
`include "bridge_params.svh"

package cache_if_pkg;

	// read miss or uncached load from a cache
	typedef struct packed
	{
		logic [`BR_ADDR_W-1:0] addr;
		logic [2:0] size;
		logic uncached; // single beat instead of a line
	} cache_rd_req_t;

	// one returned word
	typedef struct packed
	{
		logic [`BR_DATA_W-1:0] data;
		logic last;
	} cache_ret_t;

	// dirty line eviction or uncached store
	typedef struct packed
	{
		logic [`BR_ADDR_W-1:0] addr;
		logic [2:0] size;
		logic [`BR_DATA_W/8-1:0] wstrb; // only used by uncached stores
		logic uncached;
		logic [`BR_LINE_W-1:0] line; // uncached store takes word 0
	} cache_wr_req_t;

endpackage

// File: logic/rd_arbiter.sv
`timescale 1ns/100ps
`include "bridge_params.svh"

module rd_arbiter
(
	input  logic clk,
	input  logic rst,
	input  cache_if_pkg::cache_rd_req_t inst_req,
	input  logic inst_valid,
	output logic inst_rdy,
	output cache_if_pkg::cache_ret_t inst_ret,
	output logic inst_ret_valid,
	input  cache_if_pkg::cache_rd_req_t data_req,
	input  logic data_valid,
	output logic data_rdy,
	output cache_if_pkg::cache_ret_t data_ret,
	output logic data_ret_valid,
	input  logic wr_busy,
	input  logic [`BR_ADDR_W-1:0] wr_addr,
	output axi_pkg::axi_ar_t ar,
	output logic ar_valid,
	input  logic ar_ready,
	input  axi_pkg::axi_r_t r,
	input  logic r_valid
);
	localparam int off_w = $clog2(`BR_LINE_WORDS) + 2; // byte offset bits in a line
	localparam logic [`BR_ID_W-1:0] id_inst = `BR_ID_INST;
	localparam logic [`BR_ID_W-1:0] id_data = `BR_ID_DATA;

	typedef enum logic [1:0]
	{
		s_idle, // address channel free
		s_send, // ar_valid up
		s_wait  // both sources in flight
	} rd_state_t;

	rd_state_t state;
	rd_state_t state_n;
	axi_pkg::axi_ar_t ar_q;
	cache_if_pkg::cache_rd_req_t sel_req;
	logic sel_single;
	logic infl_inst;
	logic infl_data;
	logic infl_inst_n;
	logic infl_data_n;
	logic inst_hold;
	logic data_hold;
	logic inst_take;
	logic data_take;
	logic ar_done;
	logic r_is_inst;
	logic r_is_data;

	// hold reads that hit the line being written
	assign inst_hold = wr_busy
		& (inst_req.addr[`BR_ADDR_W-1:off_w] == wr_addr[`BR_ADDR_W-1:off_w]);
	assign data_hold = wr_busy
		& (data_req.addr[`BR_ADDR_W-1:off_w] == wr_addr[`BR_ADDR_W-1:off_w]);

	// both low while in reset
	assign inst_rdy = rst & (state == s_idle) & ~infl_inst & ~inst_hold;
	assign data_rdy = rst & (state == s_idle) & ~infl_data & ~inst_valid & ~data_hold; // inst first
	assign inst_take = inst_valid & inst_rdy;
	assign data_take = data_valid & data_rdy;

	assign ar_valid = (state == s_send);
	assign ar = ar_q;
	assign ar_done = ar_valid & ar_ready;

	// returning beats routed by the low id bit
	assign r_is_inst = (r.id[0] == id_inst[0]);
	assign r_is_data = (r.id[0] == id_data[0]);
	assign inst_ret_valid = r_valid & r_is_inst;
	assign data_ret_valid = r_valid & r_is_data;

	always_comb
	begin
		inst_ret.data = r.data;
		inst_ret.last = r.last;
		data_ret.data = r.data;
		data_ret.last = r.last;
	end

	// flags set at the ar handshake, cleared by that source's last beat
	assign infl_inst_n = (infl_inst & ~(r_valid & r.last & r_is_inst))
		| (ar_done & (ar_q.id[0] == id_inst[0]));
	assign infl_data_n = (infl_data & ~(r_valid & r.last & r_is_data))
		| (ar_done & (ar_q.id[0] == id_data[0]));

	always_comb
	begin
		state_n = state;
		case (state)
			s_idle:
			begin
				if (inst_take | data_take)
					state_n = s_send;
			end
			s_send:
			begin
				if (ar_ready)
					state_n = (infl_inst_n & infl_data_n) ? s_wait : s_idle;
			end
			s_wait:
			begin
				if (~(infl_inst_n & infl_data_n))
					state_n = s_idle;
			end
			default: state_n = s_idle;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
		begin
			state <= s_idle;
			infl_inst <= 1'b0;
			infl_data <= 1'b0;
		end
		else
		begin
			state <= state_n;
			infl_inst <= infl_inst_n;
			infl_data <= infl_data_n;
		end
	end

	assign sel_req = inst_take ? inst_req : data_req;
	assign sel_single = data_take & data_req.uncached; // uncached load is one fixed beat

	always_ff @(posedge clk)
	begin
		if (inst_take | data_take)
		begin
			ar_q.id <= inst_take ? id_inst : id_data;
			ar_q.addr <= sel_req.addr;
			ar_q.size <= sel_req.size;
			ar_q.len <= sel_single ? `BR_LEN_ONE : `BR_LEN_LINE;
			ar_q.burst <= sel_single ? `BR_BURST_FIXED : `BR_BURST_INCR;
		end
	end

endmodule

// File: logic/wr_burst.sv
`timescale 1ns/100ps
`include "bridge_params.svh"

module wr_burst
(
	input  logic clk,
	input  logic rst,
	input  cache_if_pkg::cache_wr_req_t req,
	input  logic valid,
	output logic rdy,
	output axi_pkg::axi_aw_t aw,
	output logic aw_valid,
	input  logic aw_ready,
	output axi_pkg::axi_w_t w,
	output logic w_valid,
	input  logic w_ready,
	input  axi_pkg::axi_b_t b,
	input  logic b_valid,
	output logic wr_busy,
	output logic [`BR_ADDR_W-1:0] wr_addr
);
	localparam int cnt_w = $clog2(`BR_LINE_WORDS);
	localparam logic [cnt_w-1:0] last_beat = cnt_w'(`BR_LINE_WORDS - 1);

	typedef enum logic [1:0]
	{
		s_free,
		s_addr, // aw_valid up
		s_data, // streaming beats
		s_resp  // waiting for b
	} wr_state_t;

	wr_state_t state;
	wr_state_t state_n;
	axi_pkg::axi_aw_t aw_q;
	logic [`BR_LINE_W-1:0] line_buf;
	logic [`BR_DATA_W/8-1:0] strb_q;
	logic single_q;
	logic [cnt_w-1:0] beat_cnt;
	logic take;
	logic beat;
	logic b_hit;

	assign rdy = (state == s_free);
	assign take = valid & rdy;
	assign beat = w_valid & w_ready;
	assign b_hit = b_valid & (b.id == aw_q.id);

	assign aw_valid = (state == s_addr);
	assign aw = aw_q;

	assign w_valid = (state == s_data);
	always_comb
	begin
		w.data = line_buf[`BR_DATA_W-1:0]; // low word always goes out next
		w.strb = single_q ? strb_q : '1;
		w.last = single_q | (beat_cnt == last_beat);
	end

	// acceptance cycle counts too, so a read in that same cycle is held
	assign wr_busy = (state != s_free) | valid;
	assign wr_addr = (state == s_free) ? req.addr : aw_q.addr;

	always_comb
	begin
		state_n = state;
		case (state)
			s_free:
			begin
				if (take)
					state_n = s_addr;
			end
			s_addr:
			begin
				if (aw_ready)
					state_n = s_data;
			end
			s_data:
			begin
				if (beat & w.last)
					state_n = s_resp;
			end
			s_resp:
			begin
				if (b_hit)
					state_n = s_free;
			end
			default: state_n = s_free;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (!rst)
			state <= s_free;
		else
			state <= state_n;
	end

	always_ff @(posedge clk)
	begin
		if (take)
		begin
			aw_q.id <= `BR_ID_DATA;
			aw_q.addr <= req.addr;
			aw_q.size <= req.size;
			aw_q.len <= req.uncached ? `BR_LEN_ONE : `BR_LEN_LINE;
			aw_q.burst <= req.uncached ? `BR_BURST_FIXED : `BR_BURST_INCR;
			line_buf <= req.line;
			strb_q <= req.wstrb;
			single_q <= req.uncached;
			beat_cnt <= '0;
		end
		else if (beat)
		begin
			line_buf <= {{`BR_DATA_W{1'b0}}, line_buf[`BR_LINE_W-1:`BR_DATA_W]}; // shift one word
			beat_cnt <= beat_cnt + 1'b1;
		end
	end

endmodule

// File: tb.f
+incdir+include
logic/axi_pkg.sv
logic/cache_if_pkg.sv
logic/rd_arbiter.sv
logic/wr_burst.sv
logic/cache_axi_bridge.sv
bench/tb_clk_gen.sv
bench/axi_mem_model.sv
bench/tb_checker.sv
bench/tb_top.sv
